// ==== mipsCore_vectors.hex ====
// Program length, then program words from address 0
// Then store count, then expected stores as byte address and data pairs
00000032
// Word 0 nop, setup r1 r2 r3 and base r10 = 0x200
00000000 34013C5A 34020FF0 2003FFFD 340A0200
// ADD SUB AND OR XOR NOR, SLT both ways, then stores
00222020 00222822 00223024 00223825 00224026 00224827 0061582A 0023602A
AD440000 AD450004 AD460008 AD47000C AD480010 AD490014 AD4B0018 AD4C001C
// ADDI SLTI SLTI ANDI ORI XORI LUI, then stores
202DFFF0 286EFFFE 282FFFFF 30708F0F 34318001 38728000 3C13A5C3
AD4D0020 AD4E0024 AD4F0028 AD50002C AD510030 AD520034 AD530038
// SW, LW same word, SW of loaded value
AD520040 8D540040 AD540044
// Flags, BEQ taken over a store, BEQ not taken
34151111 34162222 10210001 AD560048 AD55004C 10220001 AD560050 AD550054
// J over a store, final J to itself
08000030 AD560058 AD53005C 08000031
// Expected stores
00000015
00000200 00004C4A 00000204 00002C6A 00000208 00000C50 0000020C 00003FFA
00000210 000033AA 00000214 FFFFC005 00000218 00000001 0000021C 00000000
00000220 00003C4A 00000224 00000001 00000228 00000000 0000022C 00008F0D
00000230 0000BC5B 00000234 FFFF7FFD 00000238 A5C30000
00000240 FFFF7FFD 00000244 FFFF7FFD
0000024C 00001111 00000250 00002222 00000254 00001111
0000025C A5C30000

// ==== verilog.f ====
mipsPkg.sv
aluDecoder.sv
alu.sv
regFile.sv
controlUnit.sv
dataPath.sv
sharedMemory.sv
mipsCore.sv
tbClockGen.sv
mipsCore_checker.sv
tbMipsCore.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - mipsPkg.sv
  - aluDecoder.sv
  - alu.sv
  - regFile.sv
  - controlUnit.sv
  - dataPath.sv
  - sharedMemory.sv
  - mipsCore.sv
  - target: test
    files:
      - tbClockGen.sv
      - mipsCore_checker.sv
      - tbMipsCore.sv

// ==== tbMipsCore.sv ====
`default_nettype none

module tbMipsCore;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int memWords = 1024;
	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	// Loader keeps rewriting word 0 this long after reset
	localparam int holdCycles = 8;
	// Quiet time after the last store to catch strays
	localparam int drainCycles = 12;
	localparam int numGroups = 5;

	logic cclk;
	logic rstb;
	logic loadEn;
	logic [15:0] loadAddr;
	logic [31:0] loadData;
	logic storeValid;
	logic [31:0] storeAddr;
	logic [31:0] storeData;

	// Length, program, store count, then address and data pairs
	logic [31:0] vec [256];
	int progLen;
	int storeCount;
	int storesSeen;
	int groupIdx;
	int groupErrors;
	int errorCount;
	int earlyStores;
	int checkerFails;
	int testsPassed;
	int testsFailed;
	int watchdogCycles;
	logic loadDone;

	tbClockGen #(
		.period(clkPeriod)
	) uClockGen (
		.cclk(cclk)
	);

	mipsCore #(
		.memWords(memWords)
	) UUT (
		.cclk(cclk),
		.rstb(rstb),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	// Running store count at the end of each group
	function automatic int groupEnd(input int g);
		case (g)
			0: return 8;
			1: return 15;
			2: return 17;
			3: return 20;
			default: return 21;
		endcase
	endfunction

	function automatic string groupName(input int g);
		case (g)
			0: return "R-type ALU";
			1: return "I-type immediates";
			2: return "store and load round trip";
			3: return "BEQ taken and not taken";
			default: return "J over a store";
		endcase
	endfunction

	task automatic reportTest(input int num, input string name, input int errs);
		if (errs == 0) begin
			testsPassed++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			testsFailed++;
			$display("Test %0d %s: FAILED with %0d errors", num, name, errs);
		end
	endtask

	// Compare one store with the next expected pair
	task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] expAddr;
		logic [31:0] expData;
		expAddr = vec[progLen + 2 + 2 * storesSeen];
		expData = vec[progLen + 3 + 2 * storesSeen];
		assert (addr === expAddr) else begin
			$display("[ERROR] %0t storeAddr expected %h actual %h", $time, expAddr, addr);
			groupErrors++;
			errorCount++;
		end
		assert (data === expData) else begin
			$display("[ERROR] %0t storeData expected %h actual %h", $time, expData, data);
			groupErrors++;
			errorCount++;
		end
		storesSeen++;
		if (storesSeen == groupEnd(groupIdx)) begin
			reportTest(groupIdx + 1, groupName(groupIdx), groupErrors);
			groupErrors = 0;
			groupIdx++;
		end
	endtask

	// Store trace, sampled mid-cycle
	always @(negedge cclk) begin
		if (rstb === 1'b1 && storeValid === 1'b1) begin
			assert (loadDone) else begin
				$display("Store to %h at %0t came before loading ended", storeAddr, $time);
				earlyStores++;
				errorCount++;
			end
			assert (storesSeen < storeCount) else begin
				$display("Store to %h at %0t is beyond the %0d expected stores",
					storeAddr, $time, storeCount);
				errorCount++;
			end
			if (storesSeen < storeCount) begin
				checkStore(storeAddr, storeData);
			end
		end
	end

	initial begin
		$readmemh("mipsCore_vectors.hex", vec);
		progLen = vec[0];
		storeCount = vec[progLen + 1];
		watchdogCycles = progLen * 6 + resetCycles + holdCycles + progLen + 20;
		// Grant comes out of reset high, so word 0 must be valid before the first fetch
		rstb = 1'b0;
		loadEn = 1'b1;
		loadAddr = 16'd0;
		loadData = vec[1];
		loadDone = 1'b0;
		repeat (resetCycles) @(posedge cclk);
		rstb <= 1'b1;
		// Hold-off stretch, core stalled in PRE_FETCH
		repeat (holdCycles) @(posedge cclk);
		for (int i = 1; i < progLen; i++) begin
			loadAddr <= 16'(i);
			loadData <= vec[i + 1];
			@(posedge cclk);
		end
		loadEn <= 1'b0;
		loadDone <= 1'b1;
		wait (storesSeen == storeCount);
		repeat (drainCycles) @(posedge cclk);
		reportTest(numGroups + 1, "loader hold-off", earlyStores);
		// Failures of the bound control and arbitration assertions
		checkerFails = UUT.uControlUnit.uCtrlChecker.failCount
			+ UUT.uSharedMemory.uMemChecker.failCount;
		errorCount += checkerFails;
		reportTest(numGroups + 2, "bound assertions", checkerFails);
		$display("Tests passed %0d, failed %0d, errors %0d",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog sized from program and load length
	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge cclk);
		if (storesSeen < storeCount) begin
			$display("Timeout after %0d cycles, store %0d of %0d to %h never arrived",
				watchdogCycles, storesSeen + 1, storeCount, vec[progLen + 2 + 2 * storesSeen]);
		end else begin
			$display("Timeout after %0d cycles with every store seen", watchdogCycles);
		end
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mipsCore_checker.sv ====
`default_nettype none

module mipsCore_checker (
	input wire logic cclk,
	input wire logic rstb,
	input wire logic coreGnt,
	input wire logic loadEn,
	input wire mipsPkg::ctrlSignals_t ctrl,
	input wire mipsPkg::fsmState_t state
);
	timeunit 1ns;
	timeprecision 1ps;
	import mipsPkg::*;

	// Assertion failures so far
	int failCount;

	// Store and register write never share a state
	noWriteClash: assert property (@(posedge cclk) disable iff (!rstb)
		!(ctrl.memWrite && ctrl.regWrite))
		else begin
			$error("memWrite and regWrite high in the same cycle");
			failCount++;
		end

	// Stalled core leaves PRE_FETCH only with a grant
	stallHolds: assert property (@(posedge cclk) disable iff (!rstb)
		(state == PRE_FETCH && !coreGnt) |=> (state == PRE_FETCH))
		else begin
			$error("FSM left PRE_FETCH without a memory grant");
			failCount++;
		end

	// Sampled rstb keeps the reset-release edge out
	gntDrops: assert property (@(posedge cclk) disable iff (!rstb)
		(rstb && loadEn) |=> !coreGnt)
		else begin
			$error("coreGnt still high the cycle after loadEn");
			failCount++;
		end

endmodule

// FSM side, no loader here
bind controlUnit mipsCore_checker uCtrlChecker (
	.cclk(cclk),
	.rstb(rstb),
	.coreGnt(coreGnt),
	.loadEn(1'b0),
	.ctrl(ctrl),
	.state(state)
);

// Arbiter side, FSM held idle
bind sharedMemory mipsCore_checker uMemChecker (
	.cclk(cclk),
	.rstb(rstb),
	.coreGnt(coreGnt),
	.loadEn(loadReq.en),
	.ctrl(mipsPkg::ctrlSignals_t'('0)),
	.state(mipsPkg::PRE_FETCH)
);

`default_nettype wire

// ==== tbClockGen.sv ====
`default_nettype none

module tbClockGen #(
	parameter int period = 40
) (
	output logic cclk
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free-running, starts low
	initial begin
		cclk = 1'b0;
	end

	always begin
		#(period / 2) cclk = ~cclk;
	end

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`default_nettype none

module mipsCore #(
	parameter int memWords = 1024
) (
	input wire logic cclk,
	input wire logic rstb,
	input wire logic loadEn,
	input wire logic [15:0] loadAddr,
	input wire logic [31:0] loadData,
	output logic storeValid,
	output logic [31:0] storeAddr,
	output logic [31:0] storeData
);
	import mipsPkg::*;

	ctrlSignals_t ctrl;
	logic [31:0] instr;
	logic [31:0] rdata;
	logic coreGnt;
	memReq_t coreReq;
	memReq_t loadReq;

	// Loader only writes
	assign loadReq = '{en: loadEn, we: loadEn, addr: loadAddr, wdata: loadData};

	controlUnit uControlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.coreGnt(coreGnt),
		.ctrl(ctrl)
	);

	dataPath #(
		.memWords(memWords)
	) uDataPath (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.rdata(rdata),
		.instr(instr),
		.coreReq(coreReq)
	);

	sharedMemory #(
		.memWords(memWords)
	) uSharedMemory (
		.cclk(cclk),
		.rstb(rstb),
		.loadReq(loadReq),
		.coreReq(coreReq),
		.rdata(rdata),
		.coreGnt(coreGnt)
	);

	// Store trace from the core write that wins arbitration
	assign storeValid = coreReq.en & coreReq.we & coreGnt & !loadEn;
	assign storeAddr = {{(30 - memAddrBits){1'b0}}, coreReq.addr, 2'b00};
	assign storeData = coreReq.wdata;

endmodule

`default_nettype wire

// ==== sharedMemory.sv ====
`default_nettype none

module sharedMemory #(
	parameter int memWords = 1024
) (
	input wire logic cclk,
	input wire logic rstb,
	input wire mipsPkg::memReq_t loadReq,
	input wire mipsPkg::memReq_t coreReq,
	output logic [31:0] rdata,
	output logic coreGnt
);
	import mipsPkg::*;

	localparam int addrBits = $clog2(memWords);

	logic [31:0] mem [memWords];
	memReq_t winReq;

	// Loader first, core only while granted
	always_comb begin
		if (loadReq.en) begin
			winReq = loadReq;
		end else if (coreGnt) begin
			winReq = coreReq;
		end else begin
			winReq = '0;
		end
	end

	always_ff @(posedge cclk) begin
		if (winReq.en && winReq.we) begin
			mem[winReq.addr[addrBits-1:0]] <= winReq.wdata;
		end
	end

	// Core read port
	assign rdata = mem[coreReq.addr[addrBits-1:0]];

	// Grant drops after loadEn, returns one cycle after it clears
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			coreGnt <= 1'b1;
		end else begin
			coreGnt <= !loadReq.en;
		end
	end

endmodule

`default_nettype wire

// ==== dataPath.sv ====
`default_nettype none

module dataPath #(
	parameter int memWords = 1024
) (
	input wire logic cclk,
	input wire logic rstb,
	input wire mipsPkg::ctrlSignals_t ctrl,
	input wire logic [31:0] rdata,
	output logic [31:0] instr,
	output mipsPkg::memReq_t coreReq
);
	import mipsPkg::*;

	localparam int addrBits = $clog2(memWords);

	logic [31:0] pc;
	logic [31:0] mdr;
	logic [31:0] regA;
	logic [31:0] regB;
	logic [31:0] aluOut;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic aluZero;
	logic [31:0] extImm;
	logic [31:0] pcNext;
	logic [31:0] memAddr;
	logic [4:0] writeReg;
	logic [31:0] writeData;
	logic pcEn;

	regFile uRegFile (
		.cclk(cclk),
		.rstb(rstb),
		.ra1(instr[25:21]),
		.ra2(instr[20:16]),
		.wa(writeReg),
		.we(ctrl.regWrite),
		.wd(writeData),
		.rd1(rd1),
		.rd2(rd2)
	);

	alu uAlu (
		.a(srcA),
		.b(srcB),
		.aluControl(ctrl.aluControl),
		.result(aluResult),
		.zero(aluZero)
	);

	// Sign or zero extension of the immediate
	assign extImm = ctrl.extOp ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};

	always_comb begin
		srcA = (ctrl.aluSrcA == SRCA_A) ? regA : pc;
		case (ctrl.aluSrcB)
			SRCB_B: srcB = regB;
			SRCB_FOUR: srcB = 32'd4;
			SRCB_IMM: srcB = extImm;
			// Word offset for branches
			default: srcB = {extImm[29:0], 2'b00};
		endcase
		case (ctrl.pcSrc)
			PCSRC_ALUOUT: pcNext = aluOut;
			PCSRC_JUMP: pcNext = {pc[31:28], instr[25:0], 2'b00};
			default: pcNext = aluResult;
		endcase
	end

	assign writeReg = (ctrl.regDst == DST_RD) ? instr[15:11] : instr[20:16];
	assign writeData = ctrl.memToReg ? mdr : aluOut;
	assign memAddr = ctrl.iOrD ? aluOut : pc;

	// Jumps and fetch, or taken BEQ
	assign pcEn = ctrl.pcWrite | (ctrl.branch & aluZero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= 32'd0;
			instr <= 32'd0;
		end else begin
			if (pcEn) begin
				pc <= pcNext;
			end
			if (ctrl.irWrite) begin
				instr <= rdata;
			end
		end
	end

	// Non-architectural registers load every cycle
	always_ff @(posedge cclk) begin
		mdr <= rdata;
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
	end

	// Byte address to word address
	assign coreReq = '{
		en: ctrl.irWrite | ctrl.iOrD,
		we: ctrl.memWrite,
		addr: memAddrBits'(memAddr[addrBits+1:2]),
		wdata: regB
	};

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`default_nettype none

module controlUnit (
	input wire logic cclk,
	input wire logic rstb,
	input wire logic [31:0] instr,
	input wire logic coreGnt,
	output mipsPkg::ctrlSignals_t ctrl
);
	import mipsPkg::*;

	fsmState_t state;
	fsmState_t nextState;
	opcode_t opcode;
	aluOpClass_t aluOp;
	aluCtrl_t aluControl;

	assign opcode = opcode_t'(instr[31:26]);

	// Both codes go in, class picks
	aluDecoder uAluDecoder (
		.funct(funct_t'(instr[5:0])),
		.opcode(opcode),
		.aluOp(aluOp),
		.aluControl(aluControl)
	);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= PRE_FETCH;
		end else begin
			state <= nextState;
		end
	end

	// State graph
	always_comb begin
		nextState = PRE_FETCH;
		case (state)
			// Hold here until memory is granted
			PRE_FETCH: nextState = coreGnt ? FETCH : PRE_FETCH;
			FETCH: nextState = DECODE;
			DECODE: begin
				case (opcode)
					OP_LW, OP_SW: nextState = MEM_ADR;
					OP_RTYPE: nextState = EXECUTE;
					OP_BEQ: nextState = BRANCH;
					OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
						nextState = ITYPE_EXECUTE;
					end
					OP_J: nextState = JUMP;
					// Unknown opcode restarts fetch
					default: nextState = PRE_FETCH;
				endcase
			end
			MEM_ADR: begin
				if (opcode == OP_LW) begin
					nextState = MEM_READ;
				end else if (opcode == OP_SW) begin
					nextState = MEM_WRITE;
				end
			end
			MEM_READ: nextState = MEM_WRITEBACK;
			EXECUTE: nextState = ALU_WRITEBACK;
			ITYPE_EXECUTE: nextState = ITYPE_WRITEBACK;
			// Writebacks, BRANCH, JUMP and MEM_WRITE end here
			default: nextState = PRE_FETCH;
		endcase
	end

	// ALU class per state
	always_comb begin
		case (state)
			BRANCH: aluOp = ALUOP_SUB;
			EXECUTE: aluOp = ALUOP_FUNCT;
			ITYPE_EXECUTE: aluOp = ALUOP_IMM;
			default: aluOp = ALUOP_ADD;
		endcase
	end

	// Moore outputs
	always_comb begin
		ctrl = '0;
		ctrl.aluControl = aluControl;
		// Logical immediates are zero extended
		ctrl.extOp = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI});
		case (state)
			PRE_FETCH: begin
				// IR load only once granted
				ctrl.iOrD = 1'b0;
				ctrl.irWrite = coreGnt;
			end
			FETCH: begin
				// PC + 4
				ctrl.aluSrcA = SRCA_PC;
				ctrl.aluSrcB = SRCB_FOUR;
				ctrl.pcSrc = PCSRC_ALU;
				ctrl.pcWrite = 1'b1;
			end
			DECODE: begin
				// Branch target into ALUOut
				ctrl.aluSrcA = SRCA_PC;
				ctrl.aluSrcB = SRCB_BRANCH;
			end
			MEM_ADR: begin
				ctrl.aluSrcA = SRCA_A;
				ctrl.aluSrcB = SRCB_IMM;
			end
			MEM_READ: begin
				ctrl.iOrD = 1'b1;
			end
			MEM_WRITEBACK: begin
				ctrl.memToReg = 1'b1;
				ctrl.regDst = DST_RT;
				ctrl.regWrite = 1'b1;
			end
			MEM_WRITE: begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			EXECUTE: begin
				ctrl.aluSrcA = SRCA_A;
				ctrl.aluSrcB = SRCB_B;
			end
			ALU_WRITEBACK: begin
				ctrl.regDst = DST_RD;
				ctrl.regWrite = 1'b1;
			end
			BRANCH: begin
				// Compare A and B, PC from ALUOut on equal
				ctrl.aluSrcA = SRCA_A;
				ctrl.aluSrcB = SRCB_B;
				ctrl.pcSrc = PCSRC_ALUOUT;
				ctrl.branch = 1'b1;
			end
			ITYPE_EXECUTE: begin
				ctrl.aluSrcA = SRCA_A;
				ctrl.aluSrcB = SRCB_IMM;
			end
			ITYPE_WRITEBACK: begin
				ctrl.regDst = DST_RT;
				ctrl.regWrite = 1'b1;
			end
			JUMP: begin
				ctrl.pcSrc = PCSRC_JUMP;
				ctrl.pcWrite = 1'b1;
			end
			default: begin
				ctrl.irWrite = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
	input wire logic cclk,
	input wire logic rstb,
	input wire logic [4:0] ra1,
	input wire logic [4:0] ra2,
	input wire logic [4:0] wa,
	input wire logic we,
	input wire logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [32];

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (we && (wa != 5'd0)) begin
			// r0 stays hardwired
			regs[wa] <= wd;
		end
	end

	// Combinational read ports
	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
	input wire logic [31:0] a,
	input wire logic [31:0] b,
	input wire mipsPkg::aluCtrl_t aluControl,
	output logic [31:0] result,
	output logic zero
);
	import mipsPkg::*;

	logic lessThan;

	// Signed compare for SLT and SLTI
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = {31'd0, lessThan};
			// Immediate into upper half
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = a + b;
		endcase
	end

	// Equality test for BEQ
	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== aluDecoder.sv ====
`default_nettype none

module aluDecoder (
	input wire mipsPkg::funct_t funct,
	input wire mipsPkg::opcode_t opcode,
	input wire mipsPkg::aluOpClass_t aluOp,
	output mipsPkg::aluCtrl_t aluControl
);
	import mipsPkg::*;

	always_comb begin
		aluControl = ALU_ADD;
		case (aluOp)
			ALUOP_SUB: aluControl = ALU_SUB;
			// R-type operation from funct field
			ALUOP_FUNCT: begin
				case (funct)
					FN_SUB: aluControl = ALU_SUB;
					FN_AND: aluControl = ALU_AND;
					FN_OR: aluControl = ALU_OR;
					FN_XOR: aluControl = ALU_XOR;
					FN_NOR: aluControl = ALU_NOR;
					FN_SLT: aluControl = ALU_SLT;
					default: aluControl = ALU_ADD;
				endcase
			end
			// I-type operation from opcode
			ALUOP_IMM: begin
				case (opcode)
					OP_SLTI: aluControl = ALU_SLT;
					OP_ANDI: aluControl = ALU_AND;
					OP_ORI: aluControl = ALU_OR;
					OP_XORI: aluControl = ALU_XOR;
					OP_LUI: aluControl = ALU_LUI;
					default: aluControl = ALU_ADD;
				endcase
			end
			default: aluControl = ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// Width of the word address field in memory requests
	localparam int memAddrBits = 16;

	// Supported primary opcodes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J = 6'h02,
		OP_BEQ = 6'h04,
		OP_ADDI = 6'h08,
		OP_SLTI = 6'h0A,
		OP_ANDI = 6'h0C,
		OP_ORI = 6'h0D,
		OP_XORI = 6'h0E,
		OP_LUI = 6'h0F,
		OP_LW = 6'h23,
		OP_SW = 6'h2B
	} opcode_t;

	// R-type function field
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2A
	} funct_t;

	// Multicycle FSM states
	typedef enum logic [3:0] {
		FETCH = 4'd0,
		DECODE = 4'd1,
		MEM_ADR = 4'd2,
		MEM_READ = 4'd3,
		MEM_WRITEBACK = 4'd4,
		MEM_WRITE = 4'd5,
		EXECUTE = 4'd6,
		ALU_WRITEBACK = 4'd7,
		BRANCH = 4'd8,
		ITYPE_EXECUTE = 4'd9,
		ITYPE_WRITEBACK = 4'd10,
		JUMP = 4'd11,
		PRE_FETCH = 4'd12
	} fsmState_t;

	// ALU operation class from the FSM
	typedef enum logic [1:0] {
		ALUOP_ADD = 2'd0,
		ALUOP_SUB = 2'd1,
		ALUOP_FUNCT = 2'd2,
		ALUOP_IMM = 2'd3
	} aluOpClass_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR = 4'd3,
		ALU_XOR = 4'd4,
		ALU_NOR = 4'd5,
		ALU_SLT = 4'd6,
		ALU_LUI = 4'd7
	} aluCtrl_t;

	// Mux select codes
	localparam logic [1:0] SRCA_PC = 2'd0;
	localparam logic [1:0] SRCA_A = 2'd1;
	localparam logic [1:0] SRCB_B = 2'd0;
	localparam logic [1:0] SRCB_FOUR = 2'd1;
	localparam logic [1:0] SRCB_IMM = 2'd2;
	localparam logic [1:0] SRCB_BRANCH = 2'd3;
	localparam logic [1:0] PCSRC_ALU = 2'd0;
	localparam logic [1:0] PCSRC_ALUOUT = 2'd1;
	localparam logic [1:0] PCSRC_JUMP = 2'd2;
	localparam logic [1:0] DST_RT = 2'd0;
	localparam logic [1:0] DST_RD = 2'd1;

	typedef struct packed {
		logic memToReg;
		logic iOrD;
		logic [1:0] regDst;
		logic [1:0] pcSrc;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		logic branch;
		logic irWrite;
		logic memWrite;
		logic pcWrite;
		logic regWrite;
		// Set for sign extension
		logic extOp;
		aluCtrl_t aluControl;
	} ctrlSignals_t;

	// One word access to shared memory
	typedef struct packed {
		logic en;
		logic we;
		logic [memAddrBits-1:0] addr;
		logic [31:0] wdata;
	} memReq_t;

endpackage

`default_nettype wire
